// ==== files.f ====
source/divConfigPkg.sv
source/divOpPkg.sv
source/divRestoringStep.sv
source/divOperandPrep.sv
source/divIterator.sv
source/divResultFix.sv
source/intDivider.sv
test/intDividerTb.sv

// ==== Makefile ====
# Verilator build and run of the integer divider testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= intDividerTb
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: simulate clean

# the simulator's exit status is ignored, the log decides pass or fail
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== test/intDividerTb.sv ====
// integer divider testbench: directed, random, busy and flush checks against a reference model
`timescale 1ns/10ps

module intDividerTb;

  import divOpPkg::*;

  // latencies from the start edge to the cycle in which done is high
  localparam int normalLatency = 17;
  localparam int zeroLatency = 1;
  localparam int doneLimit = normalLatency + 8;
  localparam int numRandom = 500;
  localparam int directedOps = 60;
  // about 19 cycles per operation, rounded up to 20 with some slack on top
  localparam int watchdogCycles = (numRandom + directedOps) * 20 + 500;

  logic        clk = 1'b0;
  logic        reset;
  logic        start;
  logic        flush;
  divRequest   request;
  logic        busy;
  logic        done;
  logic [31:0] result;

  logic [31:0] rngState = 32'h5e87299a;
  int unsigned cycleNo = 0;
  // one entry per accepted start, popped by the compare process on done
  logic [31:0] expResult[$];
  int unsigned expCycle[$];

  intDivider i_dut (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .flush   (flush),
    .request (request),
    .busy    (busy),
    .done    (done),
    .result  (result)
  );

  always #5 clk = ~clk;

  // counts rising edges, read at falling edges where it is stable
  always @(posedge clk) cycleNo <= cycleNo + 1;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic failNow(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      failNow($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // RISC-V M-extension division rules, written straight from the ISA text
  function automatic logic [31:0] refDivide(input divOp op, input logic [31:0] a,
                                            input logic [31:0] b);
    logic [31:0] minNeg;
    logic        overflow;
    minNeg = 32'h8000_0000;
    overflow = (a == minNeg) && (b == 32'hffff_ffff);
    case (op)
      DIVU: return (b == '0) ? 32'hffff_ffff : a / b;
      REMU: return (b == '0) ? a : a % b;
      DIV: begin
        if (b == '0) return 32'hffff_ffff;
        if (overflow) return minNeg;
        // signed division in SystemVerilog truncates toward zero
        return $signed(a) / $signed(b);
      end
      default: begin
        if (b == '0) return a;
        if (overflow) return '0;
        return $signed(a) % $signed(b);
      end
    endcase
  endfunction

  // random op and operands, with a shifted divisor so quotients are not all tiny
  task automatic drawOperation(output divOp op, output logic [31:0] a, output logic [31:0] b);
    logic [3:0] shape;
    rngState = xorshift32(rngState);
    op = divOp'(rngState[1:0]);
    shape = rngState[7:4];
    rngState = xorshift32(rngState);
    a = rngState;
    rngState = xorshift32(rngState);
    b = rngState >> rngState[4:0];
    case (shape)
      4'd0: b = '0;
      4'd1: begin
        a = 32'h8000_0000;
        b = 32'hffff_ffff;
      end
      4'd2: b = 32'hffff_ffff;
      4'd3: a = a >> 16;
      default: ;
    endcase
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  // one start pulse, the expected result and done cycle are queued if asked for
  task automatic issueOp(input divOp op, input logic [31:0] a, input logic [31:0] b,
                         input bit expectDone);
    divRequest req;
    int        latency;
    req.op = op;
    req.dividend = a;
    req.divisor = b;
    @(posedge clk);
    start <= 1'b1;
    request <= req;
    @(negedge clk);
    if (busy) begin
      failNow("the divider was still busy when a new operation was started");
    end
    if (expectDone) begin
      latency = (b == '0) ? zeroLatency : normalLatency;
      expResult.push_back(refDivide(op, a, b));
      // start is sampled at the next rising edge, done follows latency edges later
      expCycle.push_back(cycleNo + 1 + latency);
    end
    @(posedge clk);
    start <= 1'b0;
  endtask

  // a start that must be refused because an operation is in flight
  task automatic pulseWhileBusy(input divOp op, input logic [31:0] a, input logic [31:0] b);
    divRequest req;
    req.op = op;
    req.dividend = a;
    req.divisor = b;
    @(posedge clk);
    start <= 1'b1;
    request <= req;
    @(negedge clk);
    if (!busy) begin
      failNow("a start meant to be ignored found the divider idle");
    end
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic waitDone(input bit busyMustStayLow);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (busyMustStayLow) begin
        checkValue("busy", {31'b0, busy}, '0);
      end
      if (waited > doneLimit) begin
        failNow("done never arrived for an accepted operation");
      end
    end while (done !== 1'b1);
  endtask

  task automatic runOp(input divOp op, input logic [31:0] a, input logic [31:0] b);
    issueOp(op, a, b, 1'b1);
    // a zero divisor bypasses the iterator, so busy must never rise
    waitDone(b == '0);
  endtask

  task automatic runPair(input divOp quotOp, input divOp remOp, input logic [31:0] a,
                         input logic [31:0] b);
    runOp(quotOp, a, b);
    runOp(remOp, a, b);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare process and watchdog
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : compareResults
    logic [31:0] want;
    int unsigned due;
    if (!reset && done) begin
      if (expResult.size() == 0) begin
        failNow("done pulsed without an accepted start waiting for it");
      end
      want = expResult.pop_front();
      due = expCycle.pop_front();
      if (cycleNo != due) begin
        failNow($sformatf("done arrived at cycle %0d instead of cycle %0d", cycleNo, due));
      end
      checkValue("result", result, want);
      // busy drops in the same cycle that done rises
      checkValue("busy", {31'b0, busy}, '0);
    end
  end

  initial begin : watchdog
    repeat (watchdogCycles) @(posedge clk);
    failNow($sformatf("timeout, the run did not finish within %0d cycles", watchdogCycles));
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    divOp        op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] heldResult;
    int          i;
    reset = 1'b1;
    start = 1'b0;
    flush = 1'b0;
    request = '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checkValue("busy", {31'b0, busy}, '0);
    checkValue("done", {31'b0, done}, '0);
    checkValue("result", result, '0);

    // unsigned corner cases
    runPair(DIVU, REMU, 32'd0, 32'd7);
    runPair(DIVU, REMU, 32'd100, 32'd1);
    runPair(DIVU, REMU, 32'd5, 32'd9);
    runPair(DIVU, REMU, 32'hffff_ffff, 32'hffff_ffff);
    runPair(DIVU, REMU, 32'hffff_ffff, 32'd1);
    runPair(DIVU, REMU, 32'hffff_ffff, 32'd2);
    runPair(DIVU, REMU, 32'h1234_5678, 32'h0000_1234);
    runPair(DIVU, REMU, 32'h8000_0000, 32'd3);

    // all four sign combinations, then the overflow case and its neighbours
    runPair(DIV, REM, 32'd100, 32'd7);
    runPair(DIV, REM, -32'd100, 32'd7);
    runPair(DIV, REM, 32'd100, -32'd7);
    runPair(DIV, REM, -32'd100, -32'd7);
    runPair(DIV, REM, 32'h8000_0000, 32'hffff_ffff);
    runPair(DIV, REM, 32'h8000_0000, 32'd1);
    runPair(DIV, REM, 32'h7fff_ffff, 32'hffff_ffff);
    runPair(DIV, REM, 32'hffff_ffff, 32'd2);

    // division by zero for every op
    runPair(DIV, REM, 32'hdead_beef, 32'd0);
    runPair(DIVU, REMU, 32'h8000_0000, 32'd0);

    // back to back random operations, each start one cycle after the last done
    for (i = 0; i < numRandom; i++) begin
      drawOperation(op, a, b);
      runOp(op, a, b);
    end

    // starts during an operation are refused, including one with a zero divisor
    issueOp(DIV, -32'd1000, 32'd7, 1'b1);
    pulseWhileBusy(REM, 32'd5, 32'd3);
    repeat (6) @(posedge clk);
    pulseWhileBusy(DIVU, 32'd9, 32'd0);
    waitDone(1'b0);
    // any second done here is caught by the compare process
    repeat (25) @(negedge clk);

    // flush aborts the operation and leaves the old result in place
    issueOp(DIVU, 32'h0001_0000, 32'd3, 1'b0);
    @(negedge clk);
    heldResult = result;
    repeat (4) @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    checkValue("busy", {31'b0, busy}, '0);
    checkValue("result", result, heldResult);
    repeat (25) @(negedge clk);
    checkValue("result", result, heldResult);
    runPair(DIV, REM, -32'd77, 32'd5);

    repeat (5) @(negedge clk);
    if (expResult.size() != 0) begin
      failNow("operations were still waiting for done at the end of the run");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// ==== source/intDivider.sv ====
// iterative integer divider for the execute stage: DIV, DIVU, REM and REMU
`timescale 1ns/10ps

module intDivider (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          start,
  input  logic                          flush,
  input  divOpPkg::divRequest           request,
  output logic                          busy,
  output logic                          done,
  output logic [divConfigPkg::xlen-1:0] result
);

  import divConfigPkg::*;
  import divOpPkg::*;

  divOperands      operands;
  logic            load;
  logic            zeroDone;
  logic            finish;
  logic [xlen-1:0] partialRemainder;
  logic [xlen-1:0] quotient;

  // operands are captured on start and stay valid until the next accepted start
  divOperandPrep u_prep (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .flush    (flush),
    .request  (request),
    .busy     (busy),
    .operands (operands),
    .load     (load),
    .zeroDone (zeroDone)
  );

  divIterator u_iter (
    .clk              (clk),
    .reset            (reset),
    .flush            (flush),
    .load             (load),
    .operands         (operands),
    .partialRemainder (partialRemainder),
    .quotient         (quotient),
    .busy             (busy),
    .finish           (finish)
  );

  // a zero divisor bypasses the iterator and reaches the fixer one cycle after start
  divResultFix u_fix (
    .clk              (clk),
    .reset            (reset),
    .operands         (operands),
    .partialRemainder (partialRemainder),
    .quotient         (quotient),
    .finish           (finish),
    .zeroDone         (zeroDone),
    .result           (result),
    .done             (done)
  );

endmodule

// ==== source/divResultFix.sv ====
// divider result stage: sign correction, divide-by-zero values and the held result register
`timescale 1ns/10ps

module divResultFix (
  input  logic                          clk,
  input  logic                          reset,
  input  divOpPkg::divOperands          operands,
  input  logic [divConfigPkg::xlen-1:0] partialRemainder,
  input  logic [divConfigPkg::xlen-1:0] quotient,
  input  logic                          finish,
  input  logic                          zeroDone,
  output logic [divConfigPkg::xlen-1:0] result,
  output logic                          done
);

  import divConfigPkg::*;

  logic [xlen-1:0] quotientFixed;
  logic [xlen-1:0] remainderFixed;
  logic [xlen-1:0] selected;
  logic            capture;

  ////////////////////////////////////////////////////////////////////////////
  // correction and selection
  ////////////////////////////////////////////////////////////////////////////

  // divide by zero returns all ones as quotient, whatever the signs were
  assign quotientFixed = operands.divByZero ? '1 :
                         operands.negQuotient ? -quotient : quotient;

  // and hands back the untouched dividend as remainder
  assign remainderFixed = operands.divByZero ? operands.rawDividend :
                          operands.negRemainder ? -partialRemainder : partialRemainder;

  assign selected = operands.wantRemainder ? remainderFixed : quotientFixed;

  ////////////////////////////////////////////////////////////////////////////
  // result register
  ////////////////////////////////////////////////////////////////////////////

  // finish and zeroDone never overlap, since busy blocks a start while iterating
  assign capture = finish | zeroDone;

  // result stays put between captures, the consumer reads it after done
  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
      done <= 1'b0;
    end else begin
      done <= capture;
      if (capture) begin
        result <= selected;
      end
    end
  end

endmodule

// ==== source/divIterator.sv ====
// divider iteration engine: remainder and quotient registers driven through two chained steps
`timescale 1ns/10ps

module divIterator (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          flush,
  input  logic                          load,
  input  divOpPkg::divOperands          operands,
  output logic [divConfigPkg::xlen-1:0] partialRemainder,
  output logic [divConfigPkg::xlen-1:0] quotient,
  output logic                          busy,
  output logic                          finish
);

  import divConfigPkg::*;

  logic                     running;
  logic                     finishPending;
  logic                     advance;
  logic [stepCountBits-1:0] stepCount;
  logic [stepCountBits-1:0] nextCount;
  logic [xlen-1:0]          partialSeed;
  logic [xlen-1:0]          quotientSeed;
  logic [xlen-1:0]          divisorInv;
  logic [xlen-1:0]          partialMid;
  logic [xlen-1:0]          quotientMid;
  logic [xlen-1:0]          partialNext;
  logic [xlen-1:0]          quotientNext;

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  // the first iteration starts from a cleared remainder and the dividend
  // magnitude, later ones feed the registers back into the chain
  assign partialSeed = load ? '0 : partialRemainder;
  assign quotientSeed = load ? operands.absDividend : quotient;
  assign divisorInv = ~operands.absDivisor;

  divRestoringStep u_step0 (
    .partialIn   (partialSeed),
    .quotientIn  (quotientSeed),
    .divisorInv  (divisorInv),
    .partialOut  (partialMid),
    .quotientOut (quotientMid)
  );

  divRestoringStep u_step1 (
    .partialIn   (partialMid),
    .quotientIn  (quotientMid),
    .divisorInv  (divisorInv),
    .partialOut  (partialNext),
    .quotientOut (quotientNext)
  );

  // registers hold during the finish cycle so the fixer samples the final values
  always_ff @(posedge clk) begin
    if (advance) begin
      partialRemainder <= partialNext;
      quotient <= quotientNext;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // step counter and control
  ////////////////////////////////////////////////////////////////////////////

  assign advance = load | (running & ~finishPending);

  // the load edge already performs the first iteration, so the count starts at one
  assign nextCount = load ? stepCountBits'(1) : stepCount + 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      running <= 1'b0;
      finishPending <= 1'b0;
      stepCount <= '0;
    end else if (flush) begin
      // abort whatever is in flight, the fixer never sees a finish
      running <= 1'b0;
      finishPending <= 1'b0;
      stepCount <= '0;
    end else if (finishPending) begin
      running <= 1'b0;
      finishPending <= 1'b0;
      stepCount <= '0;
    end else if (advance) begin
      running <= 1'b1;
      stepCount <= nextCount;
      finishPending <= (nextCount == stepCountBits'(iterCycles));
    end
  end

  // busy covers the load cycle too, so start is refused right after acceptance
  assign busy = load | running;

  // a flush arriving in the finish cycle still suppresses the result
  assign finish = finishPending & ~flush;

endmodule

// ==== source/divOperandPrep.sv ====
// divider operand preparation: captures a request, takes absolute values and flags signs
`timescale 1ns/10ps

module divOperandPrep (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  logic                   flush,
  input  divOpPkg::divRequest    request,
  input  logic                   busy,
  output divOpPkg::divOperands   operands,
  output logic                   load,
  output logic                   zeroDone
);

  import divConfigPkg::*;
  import divOpPkg::*;

  logic            accept;
  logic            isSigned;
  logic            dividendNeg;
  logic            divisorNeg;
  logic            divisorZero;
  divOperands      nextOperands;

  // a new request is taken only while the iterator is idle
  assign accept = start & ~busy & ~flush;

  ////////////////////////////////////////////////////////////////////////////
  // operation decode and sign handling
  ////////////////////////////////////////////////////////////////////////////

  assign isSigned = (request.op == DIV) | (request.op == REM);

  // sign bits only count for the signed ops, unsigned values pass as they are
  assign dividendNeg = isSigned & request.dividend[xlen-1];
  assign divisorNeg = isSigned & request.divisor[xlen-1];
  assign divisorZero = (request.divisor == '0);

  always_comb begin
    // the most negative value negates to itself, which is its correct unsigned magnitude
    nextOperands.absDividend = dividendNeg ? -request.dividend : request.dividend;
    nextOperands.absDivisor = divisorNeg ? -request.divisor : request.divisor;
    nextOperands.rawDividend = request.dividend;
    // quotient is negative when exactly one operand is negative
    nextOperands.negQuotient = dividendNeg ^ divisorNeg;
    // truncating division gives the remainder the sign of the dividend
    nextOperands.negRemainder = dividendNeg;
    nextOperands.divByZero = divisorZero;
    nextOperands.wantRemainder = (request.op == REM) | (request.op == REMU);
  end

  ////////////////////////////////////////////////////////////////////////////
  // operand register and next-cycle strobes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      operands <= nextOperands;
    end
  end

  // exactly one of load or zeroDone pulses in the cycle after an accepted start
  always_ff @(posedge clk) begin
    if (reset) begin
      load <= 1'b0;
      zeroDone <= 1'b0;
    end else begin
      load <= accept & ~divisorZero;
      zeroDone <= accept & divisorZero;
    end
  end

endmodule

// ==== source/divRestoringStep.sv ====
// one restoring division step: shift in a dividend bit, trial subtract, restore on borrow
`timescale 1ns/10ps

module divRestoringStep (
  input  logic [divConfigPkg::xlen-1:0] partialIn,
  input  logic [divConfigPkg::xlen-1:0] quotientIn,
  input  logic [divConfigPkg::xlen-1:0] divisorInv,
  output logic [divConfigPkg::xlen-1:0] partialOut,
  output logic [divConfigPkg::xlen-1:0] quotientOut
);

  import divConfigPkg::*;

  logic [xlen-1:0] shifted;
  logic [xlen-1:0] difference;
  logic            quotientBit;

  // the partial remainder stays below 2^(xlen-1) until the last shift, so its
  // top bit is always zero and dropping it loses nothing
  assign shifted = {partialIn[xlen-2:0], quotientIn[xlen-1]};

  // adding the inverted divisor plus one subtracts it, and the carry out is
  // set exactly when the shifted value is not below the divisor
  assign {quotientBit, difference} = {1'b0, shifted} + {1'b0, divisorInv} + 1'b1;

  // keep the difference on success, otherwise fall back to the shifted value
  assign partialOut = quotientBit ? difference : shifted;

  // dividend bits leave from the top while quotient bits enter at the bottom
  assign quotientOut = {quotientIn[xlen-2:0], quotientBit};

endmodule

// ==== source/divOpPkg.sv ====
// divider operation encoding and the packed structs that carry requests and operands
package divOpPkg;

  import divConfigPkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // operation encoding
  ////////////////////////////////////////////////////////////////////////////

  // low two bits of the M-extension funct3 for the divide group, so bit 0
  // marks an unsigned op and bit 1 marks a remainder op
  typedef enum logic [1:0] {
    DIV  = 2'b00,
    DIVU = 2'b01,
    REM  = 2'b10,
    REMU = 2'b11
  } divOp;

  ////////////////////////////////////////////////////////////////////////////
  // structs passed between blocks
  ////////////////////////////////////////////////////////////////////////////

  // request as presented by the execute stage, sampled together with start
  typedef struct packed {
    divOp            op;
    logic [xlen-1:0] dividend;
    logic [xlen-1:0] divisor;
  } divRequest;

  // prepared operands, held stable from the start edge until the result is taken
  typedef struct packed {
    logic [xlen-1:0] absDividend;
    logic [xlen-1:0] absDivisor;
    // dividend exactly as given, returned as the remainder on divide by zero
    logic [xlen-1:0] rawDividend;
    logic            negQuotient;
    logic            negRemainder;
    logic            divByZero;
    logic            wantRemainder;
  } divOperands;

endpackage

// ==== source/divConfigPkg.sv ====
// divider configuration: operand width and the iteration schedule of the restoring divider
package divConfigPkg;

  ////////////////////////////////////////////////////////////////////////////
  // datapath width
  ////////////////////////////////////////////////////////////////////////////

  // operand width in bits, one machine word of the execute stage
  localparam int xlen = 32;

  ////////////////////////////////////////////////////////////////////////////
  // iteration schedule
  ////////////////////////////////////////////////////////////////////////////

  // quotient bits retired per clock, one chained restoring step per bit
  localparam int stepsPerCycle = 2;

  // number of clocks spent iterating once the operands are loaded
  localparam int iterCycles = xlen / stepsPerCycle;

  // the counter must be able to hold iterCycles itself, since finish is
  // raised on the edge where the count reaches that value
  localparam int stepCountBits = $clog2(iterCycles + 1);

endpackage
